// ==== verif/cpuTestdata.txt ====
// Word count, then one program word per line (pc in the comment)
// Record count, then records: kind (1 reg write, 2 store), address, value
0000001a
20010006 // 00 addi r1, r0, 6
2002fffd // 04 addi r2, r0, -3
00221820 // 08 add  r3, r1, r2
00412022 // 0c sub  r4, r2, r1
00222824 // 10 and  r5, r1, r2
00223025 // 14 or   r6, r1, r2
0041382a // 18 slt  r7, r2, r1
0022402a // 1c slt  r8, r1, r2
ac010008 // 20 sw   r1, 8(r0)
8c090008 // 24 lw   r9, 8(r0)
10290001 // 28 beq  r1, r9, taken
200a0001 // 2c addi r10, r0, 1 (skipped)
10220001 // 30 beq  r1, r2, not taken
200a0002 // 34 addi r10, r0, 2
14220001 // 38 bne  r1, r2, taken
200b0001 // 3c addi r11, r0, 1 (skipped)
14290001 // 40 bne  r1, r9, not taken
200b0003 // 44 addi r11, r0, 3
08000014 // 48 j    0x50
200c0001 // 4c addi r12, r0, 1 (skipped)
0c000018 // 50 jal  0x60
20000007 // 54 addi r0, r0, 7
00016820 // 58 add  r13, r0, r1
08000017 // 5c j    0x5c (halt)
200c0009 // 60 addi r12, r0, 9
03e00008 // 64 jr   r31
00000010
1 00000001 00000006
1 00000002 fffffffd
1 00000003 00000003
1 00000004 fffffff7
1 00000005 00000004
1 00000006 ffffffff
1 00000007 00000001
1 00000008 00000000
2 00000008 00000006
1 00000009 00000006
1 0000000a 00000002
1 0000000b 00000003
1 0000001f 00000054
1 0000000c 00000009
1 00000000 00000007
1 0000000d 00000006

// ==== build.f ====
source/cpuPkg.sv
source/instrDecoder.sv
source/controlUnit.sv
source/regFile.sv
source/alu.sv
source/wordMemory.sv
source/pcUnit.sv
source/cpuTop.sv
verif/cpuTb_sva.sv
verif/cpuTb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the processor testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module cpuTb -f build.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim
status=$?
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
fi
exit $status

// ==== verif/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb import cpuPkg::*; ();

    logic        clk;
    logic        rst;
    loadT        load;
    retireT      retire;
    logic [31:0] testData [0:255];
    int          wordCount;
    int          recordCount;
    int          recordBase;
    int          recIdx;
    int          cycles;

    cpuTop i_cpuTop (
        .clk    (clk),
        .rst    (rst),
        .load   (load),
        .retire (retire)
    );

    bind cpuTop cpuTbSva i_cpuTbSva (
        .clk    (clk),
        .rst    (rst),
        .retire (retire),
        .pc     (pc)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] dataWord(input int idx);
        return testData[8'(idx)];
    endfunction

    // One program word per falling edge, rst still high
    task automatic loadProgram();
        for (int i = 0; i < wordCount; i++) begin
            @(negedge clk);
            load.valid = 1'b1;
            load.addr  = IMEM_ADDR_BITS'(i);
            load.data  = dataWord(1 + i);
        end
        @(negedge clk);
        load = '0;
    endtask

    task automatic checkRetire();
        logic [31:0] kind;
        logic [31:0] addr;
        logic [31:0] value;
        kind  = dataWord(recordBase + 3 * recIdx);
        addr  = dataWord(recordBase + 3 * recIdx + 1);
        value = dataWord(recordBase + 3 * recIdx + 2);
        // First retire comes from pc 0
        if (recIdx == 0) begin
            assert (retire.pc == 32'd0) else begin
                $display("CHECK FAILED at %0t: first retire at pc %h, expected pc 0",
                         $time, retire.pc);
                $display("TESTS FAILED");
                $fatal(1, "first retire not from pc 0");
            end
        end
        if (retire.regValid) begin
            assert (kind == 32'd1 && addr == {27'd0, retire.regAddr}
                    && value == retire.regData) else begin
                $display("CHECK FAILED at %0t: record %0d, pc %h wrote r%0d = %h",
                         $time, recIdx, retire.pc, retire.regAddr, retire.regData);
                $display("    expected kind %0d addr %h value %h", kind, addr, value);
                $display("TESTS FAILED");
                $fatal(1, "register write mismatch");
            end
        end else begin
            assert (kind == 32'd2 && addr == retire.storeAddr
                    && value == retire.storeData) else begin
                $display("CHECK FAILED at %0t: record %0d, pc %h stored %h at %h",
                         $time, recIdx, retire.pc, retire.storeData, retire.storeAddr);
                $display("    expected kind %0d addr %h value %h", kind, addr, value);
                $display("TESTS FAILED");
                $fatal(1, "store mismatch");
            end
        end
        recIdx++;
    endtask

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        load = '0;
        $readmemh("verif/cpuTestdata.txt", testData);
        wordCount   = int'(testData[0]);
        recordCount = int'(dataWord(wordCount + 1));
        recordBase  = wordCount + 2;
        if (wordCount <= 0 || recordCount <= 0) begin
            $display("Test data file is missing or holds no program or no records");
            $display("TESTS FAILED");
            $fatal(1, "bad test data file");
        end

        loadProgram();
        repeat (8) @(negedge clk);
        rst = 1'b0;

        recIdx = 0;
        cycles = 0;
        while (recIdx < recordCount) begin
            @(posedge clk);
            cycles++;
            if (cycles > 500) begin
                $display("Timeout after 500 cycles with %0d of %0d retire records seen",
                         recIdx, recordCount);
                $display("TESTS FAILED");
                $fatal(1, "run timeout");
            end
            if (retire.regValid || retire.storeValid) begin
                checkRetire();
            end
        end

        $display("TESTS PASSED");
        $finish;
    end

endmodule

// ==== verif/cpuTb_sva.sv ====
`timescale 1ns/1ps

module cpuTbSva import cpuPkg::*; (
    input logic        clk,
    input logic        rst,
    input retireT      retire,
    input logic [31:0] pc
);

    // Nothing retires under reset
    noRetireInReset: assert property (
        @(posedge clk) rst |-> !(retire.regValid || retire.storeValid)
    ) else $error("retire valid while rst is high");

    oneRetireKind: assert property (
        @(posedge clk) disable iff (rst) !(retire.regValid && retire.storeValid)
    ) else $error("store and register write retired in the same cycle");

    pcAligned: assert property (
        @(posedge clk) disable iff (rst) pc[1:0] == 2'b00
    ) else $error("pc %h is not word aligned", pc);

endmodule

// ==== source/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop import cpuPkg::*; (
    input  logic   clk,
    input  logic   rst,
    input  loadT   load,
    output retireT retire
);

    logic [31:0]               pc;
    logic [31:0]               pcPlusFour;
    logic [IMEM_ADDR_BITS-1:0] imemAddr;
    logic [31:0]               instr;
    decodedT                   fields;
    ctrlT                      ctrl;
    logic [31:0]               rsValue;
    logic [31:0]               rtValue;
    logic [31:0]               aluB;
    logic [31:0]               aluResult;
    logic                      zero;
    logic [31:0]               memData;
    logic [4:0]                writeAddr;
    logic [31:0]               writeData;
    logic                      regWriteEn;
    logic                      memWriteEn;

    // Load port shares the instruction memory address during reset
    assign imemAddr = load.valid ? load.addr : pc[IMEM_ADDR_BITS+1:2];

    wordMemory #(.ADDR_BITS(IMEM_ADDR_BITS)) i_imem (
        .clk       (clk),
        .writeEn   (load.valid),
        .addr      (imemAddr),
        .writeData (load.data),
        .readData  (instr)
    );

    instrDecoder i_instrDecoder (
        .instr  (instr),
        .fields (fields)
    );

    controlUnit i_controlUnit (
        .opcode (fields.opcode),
        .funct  (fields.funct),
        .ctrl   (ctrl)
    );

    // No writes land while in reset
    assign regWriteEn = ctrl.regWrite & ~rst;
    assign memWriteEn = ctrl.memWrite & ~rst;

    assign writeAddr = ctrl.jalLink ? 5'd31 : (ctrl.regDest ? fields.rd : fields.rt);
    assign writeData = ctrl.jalLink  ? pcPlusFour :
                       ctrl.memToReg ? memData : aluResult;

    regFile i_regFile (
        .clk     (clk),
        .addrA   (fields.rs),
        .addrB   (fields.rt),
        .addrW   (writeAddr),
        .dataW   (writeData),
        .writeEn (regWriteEn),
        .dataA   (rsValue),
        .dataB   (rtValue)
    );

    assign aluB = ctrl.aluSrc ? fields.imm : rtValue;

    alu i_alu (
        .op     (ctrl.aluOp),
        .a      (rsValue),
        .b      (aluB),
        .result (aluResult),
        .zero   (zero)
    );

    wordMemory #(.ADDR_BITS(DMEM_ADDR_BITS)) i_dmem (
        .clk       (clk),
        .writeEn   (memWriteEn),
        .addr      (aluResult[DMEM_ADDR_BITS+1:2]),
        .writeData (rtValue),
        .readData  (memData)
    );

    pcUnit i_pcUnit (
        .clk        (clk),
        .rst        (rst),
        .ctrl       (ctrl),
        .zero       (zero),
        .imm        (fields.imm),
        .jumpIndex  (fields.jumpIndex),
        .rsValue    (rsValue),
        .pc         (pc),
        .pcPlusFour (pcPlusFour)
    );

    always_comb begin
        retire.pc         = pc;
        retire.regValid   = regWriteEn;
        retire.regAddr    = writeAddr;
        retire.regData    = writeData;
        retire.storeValid = memWriteEn;
        retire.storeAddr  = aluResult;
        retire.storeData  = rtValue;
    end

endmodule

// ==== source/pcUnit.sv ====
`timescale 1ns/1ps

module pcUnit import cpuPkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  ctrlT        ctrl,
    input  logic        zero,
    input  logic [31:0] imm,
    input  logic [25:0] jumpIndex,
    input  logic [31:0] rsValue,
    output logic [31:0] pc,
    output logic [31:0] pcPlusFour
);

    logic [31:0] branchTarget;
    logic [31:0] jumpTarget;
    logic        branchTaken;
    logic [31:0] pcNext;

    assign pcPlusFour   = pc + 32'd4;
    assign branchTarget = pcPlusFour + {imm[29:0], 2'b00};
    assign jumpTarget   = {pcPlusFour[31:28], jumpIndex, 2'b00};

    // beq on zero, bne on nonzero
    assign branchTaken = (ctrl.branchEq & zero) | (ctrl.branchNe & ~zero);

    always_comb begin
        if (ctrl.jumpReg) begin
            pcNext = rsValue;
        end else if (ctrl.jump) begin
            pcNext = jumpTarget;
        end else if (branchTaken) begin
            pcNext = branchTarget;
        end else begin
            pcNext = pcPlusFour;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= 32'd0;
        end else begin
            pc <= pcNext;
        end
    end

endmodule

// ==== source/wordMemory.sv ====
`timescale 1ns/1ps

module wordMemory #(
    parameter int ADDR_BITS = 8
) (
    input  logic                 clk,
    input  logic                 writeEn,
    input  logic [ADDR_BITS-1:0] addr,
    input  logic [31:0]          writeData,
    output logic [31:0]          readData
);

    logic [31:0] mem [2**ADDR_BITS];

    always_ff @(posedge clk) begin
        if (writeEn) begin
            mem[addr] <= writeData;
        end
    end

    // Combinational read
    assign readData = mem[addr];

endmodule

// ==== source/alu.sv ====
`timescale 1ns/1ps

module alu import cpuPkg::*; (
    input  aluOpT       op,
    input  logic [31:0] a,
    input  logic [31:0] b,
    output logic [31:0] result,
    output logic        zero
);

    always_comb begin
        case (op)
            ALU_ADD: result = a + b;
            ALU_SUB: result = a - b;
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            // Signed compare, result is 1 or 0
            ALU_SLT: result = ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default: result = 32'd0;
        endcase
    end

    assign zero = (result == 32'd0);

endmodule

// ==== source/regFile.sv ====
`timescale 1ns/1ps

module regFile (
    input  logic        clk,
    input  logic [4:0]  addrA,
    input  logic [4:0]  addrB,
    input  logic [4:0]  addrW,
    input  logic [31:0] dataW,
    input  logic        writeEn,
    output logic [31:0] dataA,
    output logic [31:0] dataB
);

    logic [31:0] regs [32];

    // Register 0 is never written
    always_ff @(posedge clk) begin
        if (writeEn && addrW != 5'd0) begin
            regs[addrW] <= dataW;
        end
    end

    assign dataA = (addrA == 5'd0) ? 32'd0 : regs[addrA];
    assign dataB = (addrB == 5'd0) ? 32'd0 : regs[addrB];

endmodule

// ==== source/controlUnit.sv ====
`timescale 1ns/1ps

module controlUnit import cpuPkg::*; (
    input  opcodeT opcode,
    input  functT  funct,
    output ctrlT   ctrl
);

    always_comb begin
        // Unknown codes fall through as a no-op
        ctrl = '0;
        ctrl.aluOp = ALU_ADD;
        case (opcode)
            OP_RTYPE: begin
                ctrl.regDest  = 1'b1;
                ctrl.regWrite = 1'b1;
                case (funct)
                    FN_ADD: ctrl.aluOp = ALU_ADD;
                    FN_SUB: ctrl.aluOp = ALU_SUB;
                    FN_AND: ctrl.aluOp = ALU_AND;
                    FN_OR:  ctrl.aluOp = ALU_OR;
                    FN_SLT: ctrl.aluOp = ALU_SLT;
                    FN_JR: begin
                        ctrl.regDest  = 1'b0;
                        ctrl.regWrite = 1'b0;
                        ctrl.jumpReg  = 1'b1;
                    end
                    default: begin
                        ctrl.regDest  = 1'b0;
                        ctrl.regWrite = 1'b0;
                    end
                endcase
            end
            OP_ADDI: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_LW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memToReg = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            OP_SW: begin
                ctrl.aluSrc   = 1'b1;
                ctrl.memWrite = 1'b1;
            end
            OP_BEQ: begin
                ctrl.branchEq = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_BNE: begin
                ctrl.branchNe = 1'b1;
                ctrl.aluOp    = ALU_SUB;
            end
            OP_J: ctrl.jump = 1'b1;
            OP_JAL: begin
                ctrl.jump     = 1'b1;
                ctrl.jalLink  = 1'b1;
                ctrl.regWrite = 1'b1;
            end
            default: ctrl = '0;
        endcase
    end

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/1ps

module instrDecoder import cpuPkg::*; (
    input  logic [31:0] instr,
    output decodedT     fields
);

    always_comb begin
        fields.opcode = opcodeT'(instr[31:26]);
        fields.rs     = instr[25:21];
        fields.rt     = instr[20:16];
        fields.rd     = instr[15:11];
        fields.shamt  = instr[10:6];
        fields.funct  = functT'(instr[5:0]);

        // Sign-extend the 16-bit immediate
        fields.imm       = {{16{instr[15]}}, instr[15:0]};
        fields.jumpIndex = instr[25:0];
    end

endmodule

// ==== source/cpuPkg.sv ====
package cpuPkg;

    // Word-address widths of the two memories
    localparam int IMEM_ADDR_BITS = 8;
    localparam int DMEM_ADDR_BITS = 8;

    typedef enum logic [5:0] {
        OP_RTYPE = 6'h00,
        OP_J     = 6'h02,
        OP_JAL   = 6'h03,
        OP_BEQ   = 6'h04,
        OP_BNE   = 6'h05,
        OP_ADDI  = 6'h08,
        OP_LW    = 6'h23,
        OP_SW    = 6'h2b
    } opcodeT;

    typedef enum logic [5:0] {
        FN_JR  = 6'h08,
        FN_ADD = 6'h20,
        FN_SUB = 6'h22,
        FN_AND = 6'h24,
        FN_OR  = 6'h25,
        FN_SLT = 6'h2a
    } functT;

    typedef enum logic [2:0] {
        ALU_ADD = 3'd0,
        ALU_SUB = 3'd1,
        ALU_AND = 3'd2,
        ALU_OR  = 3'd3,
        ALU_SLT = 3'd4
    } aluOpT;

    typedef struct packed {
        logic   regDest;
        logic   aluSrc;
        logic   memToReg;
        logic   memWrite;
        logic   regWrite;
        logic   branchEq;
        logic   branchNe;
        logic   jump;
        logic   jumpReg;
        logic   jalLink;
        aluOpT  aluOp;
    } ctrlT;

    typedef struct packed {
        opcodeT      opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [4:0]  rd;
        logic [4:0]  shamt;
        functT       funct;
        logic [31:0] imm;
        logic [25:0] jumpIndex;
    } decodedT;

    // Program load strobe, one word per cycle
    typedef struct packed {
        logic                      valid;
        logic [IMEM_ADDR_BITS-1:0] addr;
        logic [31:0]               data;
    } loadT;

    typedef struct packed {
        logic [31:0] pc;
        logic        regValid;
        logic [4:0]  regAddr;
        logic [31:0] regData;
        logic        storeValid;
        logic [31:0] storeAddr;
        logic [31:0] storeData;
    } retireT;

endpackage
